// ==== source/icache_pkg.sv ====
// shared definitions of the two-way instruction cache
// cache geometry, the address view used by all blocks and
// the controller state encoding

`default_nettype none

package icache_pkg;

  //////////////////////
  // geometry
  //////////////////////

  // physical address and fetch word
  localparam int unsigned addr_width     = 16;
  localparam int unsigned word_width     = 32;
  // one refill line holds four fetch words
  localparam int unsigned line_width     = 128;
  localparam int unsigned num_sets       = 16;
  localparam int unsigned num_ways       = 2;
  localparam int unsigned offset_width   = 4;
  localparam int unsigned index_width    = 4;
  localparam int unsigned tag_width      = 8;
  localparam int unsigned way_idx_width  = 1;
  // word position inside a line
  localparam int unsigned word_sel_width = 2;
  // replacement lfsr length
  localparam int unsigned lfsr_width     = 8;

  //////////////////////
  // address word
  //////////////////////

  // flat view goes to the refill port, field view addresses the arrays
  typedef union packed {
    logic [addr_width-1:0] flat;
    struct packed {
      logic [tag_width-1:0]                   tag;
      logic [index_width-1:0]                 index;
      logic [word_sel_width-1:0]              word;
      logic [offset_width-word_sel_width-1:0] byte_off;
    } fields;
  } paddr_u;

  // controller states
  typedef enum logic [2:0] {
    st_flush,
    st_idle,
    st_lookup,
    st_refill_req,
    st_refill_wait,
    st_inval
  } ctrl_state_e;

endpackage

`default_nettype wire

// ==== source/icache_tag_store.sv ====
// tag side of the instruction cache
// per-way tag arrays, valid flops, hit compare,
// victim choice and the replacement lfsr

`default_nettype none

module icache_tag_store (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 rd_en_i,
  input  logic [icache_pkg::index_width-1:0]   index_i,
  input  logic [icache_pkg::tag_width-1:0]     tag_i,
  input  logic                                 fill_i,
  input  logic [icache_pkg::tag_width-1:0]     fill_tag_i,
  input  logic                                 clr_i,
  input  logic [icache_pkg::index_width-1:0]   clr_index_i,
  input  logic [icache_pkg::tag_width-1:0]     clr_tag_i,
  input  logic                                 clr_all_i,
  output logic [icache_pkg::num_ways-1:0]      hit_o,
  output logic [icache_pkg::way_idx_width-1:0] victim_way_o
);

  // tag arrays and the registered read port
  logic [icache_pkg::tag_width-1:0] tag_mem  [icache_pkg::num_ways-1:0][icache_pkg::num_sets-1:0];
  logic [icache_pkg::tag_width-1:0] tag_rd_q [icache_pkg::num_ways-1:0];
  logic [icache_pkg::num_ways-1:0][icache_pkg::num_sets-1:0] valid_q;
  logic [icache_pkg::index_width-1:0]   idx_q;
  logic                                 cmp_q;
  logic [icache_pkg::num_ways-1:0]      vld_rd;
  logic [icache_pkg::num_ways-1:0]      clr_match;
  // replacement
  logic [icache_pkg::way_idx_width-1:0] inv_way;
  logic                                 all_valid;
  logic                                 all_valid_q;
  logic [icache_pkg::way_idx_width-1:0] victim_q;
  logic [icache_pkg::lfsr_width-1:0]    lfsr_q;

  for (genvar w = 0; w < icache_pkg::num_ways; w++) begin : gen_way
    // valid bits are read live, so a clear between read and compare is seen
    assign vld_rd[w]    = valid_q[w][idx_q];
    assign hit_o[w]     = vld_rd[w] & (tag_rd_q[w] == tag_i);
    assign clr_match[w] = valid_q[w][clr_index_i] & (tag_mem[w][clr_index_i] == clr_tag_i);
  end

  // lowest invalid way of the looked-up set
  always_comb begin
    inv_way   = '0;
    all_valid = 1'b1;
    for (int w = icache_pkg::num_ways - 1; w >= 0; w--) begin
      if (!vld_rd[w]) begin
        inv_way   = w[icache_pkg::way_idx_width-1:0];
        all_valid = 1'b0;
      end
    end
  end

  assign victim_way_o = victim_q;

  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      for (int w = 0; w < icache_pkg::num_ways; w++) begin
        tag_rd_q[w] <= tag_mem[w][index_i];
      end
    end
    if (fill_i) begin
      tag_mem[victim_q][index_i] <= fill_tag_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q     <= '0;
      idx_q       <= '0;
      cmp_q       <= 1'b0;
      victim_q    <= '0;
      all_valid_q <= 1'b0;
      lfsr_q      <= '1;
    end else begin
      cmp_q <= rd_en_i;
      if (rd_en_i) begin
        idx_q <= index_i;
      end
      // victim is frozen at the compare cycle
      if (cmp_q) begin
        victim_q    <= all_valid ? lfsr_q[icache_pkg::way_idx_width-1:0] : inv_way;
        all_valid_q <= all_valid;
      end
      if (fill_i) begin
        valid_q[victim_q][index_i] <= 1'b1;
        // taps 8,6,5,4
        if (all_valid_q) begin
          lfsr_q <= {lfsr_q[icache_pkg::lfsr_width-2:0],
                     lfsr_q[icache_pkg::lfsr_width-1] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
        end
      end
      // single-line clear or whole set for a flush
      if (clr_i) begin
        for (int w = 0; w < icache_pkg::num_ways; w++) begin
          if (clr_all_i || clr_match[w]) begin
            valid_q[w][clr_index_i] <= 1'b0;
          end
        end
      end
    end
  end

  //////////////////////
  // assertions
  //////////////////////

  a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_en_i |=> $onehot0(hit_o));

  a_fill_clr_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(fill_i && clr_i));

endmodule

`default_nettype wire

// ==== source/icache_data_store.sv ====
// data side of the instruction cache
// per-way line arrays, registered read and
// word select for each way

`default_nettype none

module icache_data_store (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  rd_en_i,
  input  logic [icache_pkg::index_width-1:0]    index_i,
  input  logic [icache_pkg::word_sel_width-1:0] word_sel_i,
  input  logic                                  fill_i,
  input  logic [icache_pkg::way_idx_width-1:0]  fill_way_i,
  input  logic [icache_pkg::line_width-1:0]     fill_line_i,
  output logic [icache_pkg::num_ways-1:0][icache_pkg::word_width-1:0] way_words_o
);

  logic [icache_pkg::line_width-1:0] line_mem [icache_pkg::num_ways-1:0][icache_pkg::num_sets-1:0];
  logic [icache_pkg::line_width-1:0] line_q   [icache_pkg::num_ways-1:0];

  // whole-line write on refill, all ways read together
  always_ff @(posedge clk_i) begin
    if (fill_i) begin
      line_mem[fill_way_i][index_i] <= fill_line_i;
    end
    if (rd_en_i) begin
      for (int w = 0; w < icache_pkg::num_ways; w++) begin
        line_q[w] <= line_mem[w][index_i];
      end
    end
  end

  // word pick happens after the read register
  for (genvar w = 0; w < icache_pkg::num_ways; w++) begin : gen_sel
    assign way_words_o[w] = line_q[w][word_sel_i*icache_pkg::word_width +: icache_pkg::word_width];
  end

  //////////////////////
  // assertions
  //////////////////////

  // the compare cycle after a read never carries a refill
  a_no_fill_after_rd: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_en_i |=> !fill_i);

endmodule

`default_nettype wire

// ==== source/icache_ctrl.sv ====
// instruction cache controller
// fetch, miss, flush and invalidate state machine,
// address registers and the fetch word mux

`default_nettype none

module icache_ctrl (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  flush_i,
  // fetch port
  input  logic                                  fetch_req_i,
  input  icache_pkg::paddr_u                    fetch_addr_i,
  output logic                                  fetch_ready_o,
  output logic                                  fetch_valid_o,
  output logic [icache_pkg::word_width-1:0]     fetch_data_o,
  // refill port
  output logic                                  mem_req_o,
  output logic [icache_pkg::addr_width-1:0]     mem_addr_o,
  input  logic                                  mem_ack_i,
  input  logic                                  mem_rtrn_vld_i,
  input  logic [icache_pkg::line_width-1:0]     mem_rtrn_data_i,
  output logic                                  miss_o,
  // invalidate port
  input  logic                                  mem_inv_req_i,
  input  logic [icache_pkg::addr_width-1:0]     mem_inv_addr_i,
  output logic                                  mem_inv_ack_o,
  // store control
  output logic                                  rd_en_o,
  output logic [icache_pkg::index_width-1:0]    index_o,
  output logic [icache_pkg::tag_width-1:0]      tag_o,
  output logic [icache_pkg::word_sel_width-1:0] word_sel_o,
  output logic                                  fill_o,
  output logic [icache_pkg::way_idx_width-1:0]  fill_way_o,
  output logic                                  clr_o,
  output logic [icache_pkg::index_width-1:0]    clr_index_o,
  output logic [icache_pkg::tag_width-1:0]      clr_tag_o,
  output logic                                  clr_all_o,
  input  logic [icache_pkg::num_ways-1:0]       hit_i,
  input  logic [icache_pkg::way_idx_width-1:0]  victim_way_i,
  input  logic [icache_pkg::num_ways-1:0][icache_pkg::word_width-1:0] way_words_i
);

  icache_pkg::ctrl_state_e            state_q, state_d;
  logic                               flush_q, flush_pend;
  logic [icache_pkg::index_width-1:0] flush_cnt_q;
  icache_pkg::paddr_u                 addr_q, inv_addr_q, line_addr;
  logic                               hit_vld_q, refill_vld, inv_take;
  logic [icache_pkg::word_width-1:0]  hit_data_q, hit_word, rtrn_word;

  // a flush pulse counts as pending in its own cycle
  assign flush_pend = flush_q | flush_i;
  assign inv_take   = (state_q == icache_pkg::st_idle) & mem_inv_req_i & mem_inv_ack_o;

  //////////////////////
  // state machine
  //////////////////////

  always_comb begin
    state_d       = state_q;
    fetch_ready_o = 1'b0;
    rd_en_o       = 1'b0;
    mem_req_o     = 1'b0;
    miss_o        = 1'b0;
    fill_o        = 1'b0;
    clr_o         = 1'b0;
    clr_all_o     = 1'b0;
    mem_inv_ack_o = 1'b0;
    refill_vld    = 1'b0;
    unique case (state_q)
      // one set per cycle and any invalidate is covered by it
      icache_pkg::st_flush: begin
        clr_o         = 1'b1;
        clr_all_o     = 1'b1;
        mem_inv_ack_o = 1'b1;
        if (&flush_cnt_q) begin
          state_d = icache_pkg::st_idle;
        end
      end
      icache_pkg::st_idle: begin
        if (flush_pend) begin
          state_d = icache_pkg::st_flush;
        end else begin
          fetch_ready_o = 1'b1;
          if (fetch_req_i) begin
            // array read on the incoming index
            rd_en_o = 1'b1;
            state_d = icache_pkg::st_lookup;
          end else begin
            mem_inv_ack_o = 1'b1;
            if (mem_inv_req_i) begin
              state_d = icache_pkg::st_inval;
            end
          end
        end
      end
      // tag compare with the hit word going out registered
      icache_pkg::st_lookup: begin
        state_d = (|hit_i) ? icache_pkg::st_idle : icache_pkg::st_refill_req;
      end
      icache_pkg::st_refill_req: begin
        mem_req_o = 1'b1;
        if (mem_ack_i) begin
          miss_o  = 1'b1;
          state_d = icache_pkg::st_refill_wait;
        end
      end
      // return is consumed at once
      icache_pkg::st_refill_wait: begin
        if (mem_rtrn_vld_i) begin
          refill_vld = 1'b1;
          fill_o     = 1'b1;
          state_d    = icache_pkg::st_idle;
        end
      end
      icache_pkg::st_inval: begin
        clr_o   = 1'b1;
        state_d = icache_pkg::st_idle;
      end
      default: begin
        state_d = icache_pkg::st_flush;
      end
    endcase
  end

  //////////////////////
  // datapath
  //////////////////////

  // arrays see the live index only while a request comes in
  assign index_o     = (state_q == icache_pkg::st_idle) ? fetch_addr_i.fields.index
                                                        : addr_q.fields.index;
  assign tag_o       = addr_q.fields.tag;
  assign word_sel_o  = addr_q.fields.word;
  assign fill_way_o  = victim_way_i;
  assign clr_index_o = (state_q == icache_pkg::st_flush) ? flush_cnt_q : inv_addr_q.fields.index;
  assign clr_tag_o   = inv_addr_q.fields.tag;

  // refill address is the line base
  always_comb begin
    line_addr                 = addr_q;
    line_addr.fields.word     = '0;
    line_addr.fields.byte_off = '0;
  end
  assign mem_addr_o = line_addr.flat;

  // and-or mux over the one-hot hit vector
  always_comb begin
    hit_word = '0;
    for (int w = 0; w < icache_pkg::num_ways; w++) begin
      hit_word |= way_words_i[w] & {icache_pkg::word_width{hit_i[w]}};
    end
  end

  assign rtrn_word = mem_rtrn_data_i[addr_q.fields.word*icache_pkg::word_width +:
                                     icache_pkg::word_width];

  assign fetch_valid_o = hit_vld_q | refill_vld;
  assign fetch_data_o  = hit_vld_q ? hit_data_q : rtrn_word;

  always_ff @(posedge clk_i) begin
    if (fetch_req_i && fetch_ready_o) begin
      addr_q <= fetch_addr_i;
    end
    if (inv_take) begin
      inv_addr_q.flat <= mem_inv_addr_i;
    end
    hit_data_q <= hit_word;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= icache_pkg::st_idle;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
      hit_vld_q   <= 1'b0;
    end else begin
      state_q     <= state_d;
      // pending flag drops as the flush starts
      flush_q     <= (state_q == icache_pkg::st_idle) ? 1'b0 : flush_pend;
      flush_cnt_q <= (state_q == icache_pkg::st_flush) ? flush_cnt_q + 1'b1 : '0;
      hit_vld_q   <= (state_q == icache_pkg::st_lookup) & (|hit_i);
    end
  end

  //////////////////////
  // assertions
  //////////////////////

  a_legal_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {icache_pkg::st_flush, icache_pkg::st_idle, icache_pkg::st_lookup,
                    icache_pkg::st_refill_req, icache_pkg::st_refill_wait,
                    icache_pkg::st_inval});

endmodule

`default_nettype wire

// ==== source/icache_top.sv ====
// top level of the two-way instruction cache
// tag store and data store share the set index,
// the controller joins hits and way words

`default_nettype none

module icache_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              flush_i,
  // fetch port
  input  logic                              fetch_req_i,
  input  logic [icache_pkg::addr_width-1:0] fetch_addr_i,
  output logic                              fetch_ready_o,
  output logic                              fetch_valid_o,
  output logic [icache_pkg::word_width-1:0] fetch_data_o,
  output logic                              miss_o,
  // refill port
  output logic                              mem_req_o,
  output logic [icache_pkg::addr_width-1:0] mem_addr_o,
  input  logic                              mem_ack_i,
  input  logic                              mem_rtrn_vld_i,
  input  logic [icache_pkg::line_width-1:0] mem_rtrn_data_i,
  // invalidate port
  input  logic                              mem_inv_req_i,
  input  logic [icache_pkg::addr_width-1:0] mem_inv_addr_i,
  output logic                              mem_inv_ack_o
);

  logic                                  rd_en, fill, clr, clr_all;
  logic [icache_pkg::index_width-1:0]    index, clr_index;
  logic [icache_pkg::tag_width-1:0]      tag, clr_tag;
  logic [icache_pkg::word_sel_width-1:0] word_sel;
  logic [icache_pkg::way_idx_width-1:0]  fill_way, victim_way;
  logic [icache_pkg::num_ways-1:0]       hit;
  logic [icache_pkg::num_ways-1:0][icache_pkg::word_width-1:0] way_words;

  // lookup tag also serves as the fill tag
  icache_tag_store u_tag_store (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rd_en_i      (rd_en),
    .index_i      (index),
    .tag_i        (tag),
    .fill_i       (fill),
    .fill_tag_i   (tag),
    .clr_i        (clr),
    .clr_index_i  (clr_index),
    .clr_tag_i    (clr_tag),
    .clr_all_i    (clr_all),
    .hit_o        (hit),
    .victim_way_o (victim_way)
  );

  icache_data_store u_data_store (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_en_i     (rd_en),
    .index_i     (index),
    .word_sel_i  (word_sel),
    .fill_i      (fill),
    .fill_way_i  (fill_way),
    .fill_line_i (mem_rtrn_data_i),
    .way_words_o (way_words)
  );

  icache_ctrl u_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .fetch_req_i     (fetch_req_i),
    .fetch_addr_i    (fetch_addr_i),
    .fetch_ready_o   (fetch_ready_o),
    .fetch_valid_o   (fetch_valid_o),
    .fetch_data_o    (fetch_data_o),
    .mem_req_o       (mem_req_o),
    .mem_addr_o      (mem_addr_o),
    .mem_ack_i       (mem_ack_i),
    .mem_rtrn_vld_i  (mem_rtrn_vld_i),
    .mem_rtrn_data_i (mem_rtrn_data_i),
    .miss_o          (miss_o),
    .mem_inv_req_i   (mem_inv_req_i),
    .mem_inv_addr_i  (mem_inv_addr_i),
    .mem_inv_ack_o   (mem_inv_ack_o),
    .rd_en_o         (rd_en),
    .index_o         (index),
    .tag_o           (tag),
    .word_sel_o      (word_sel),
    .fill_o          (fill),
    .fill_way_o      (fill_way),
    .clr_o           (clr),
    .clr_index_o     (clr_index),
    .clr_tag_o       (clr_tag),
    .clr_all_o       (clr_all),
    .hit_i           (hit),
    .victim_way_i    (victim_way),
    .way_words_i     (way_words)
  );

endmodule

`default_nettype wire

// ==== verification/tb_checker.sv ====
// checker of the instruction cache testbench
// residency model, data, refill address, hit latency,
// forced-miss and handshake checks with per-test report lines

`default_nettype none

module tb_checker (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         flush_i,
  input  logic         fetch_req_i,
  input  logic [15:0]  fetch_addr_i,
  input  logic         fetch_ready_i,
  input  logic         fetch_valid_i,
  input  logic [31:0]  fetch_data_i,
  input  logic         miss_i,
  input  logic         mem_req_i,
  input  logic [15:0]  mem_addr_i,
  input  logic         mem_inv_req_i,
  input  logic [15:0]  mem_inv_addr_i,
  input  logic         mem_inv_ack_i,
  input  logic         test_end_i,
  input  logic [1:0]   test_id_i,
  output int           err_cnt_o,
  output int           check_cnt_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // known resident and known absent flags per line
  bit                 resident [4096];
  bit                 absent   [4096];
  bit                 pending, saw_req, saw_miss, exp_hit, exp_miss;
  icache_pkg::paddr_u pend_addr;
  int                 cyc, acc_cyc, test_err, test_chk, flush_left;

  // expected word built from the line base and the word position
  function automatic logic [31:0] exp_word(input icache_pkg::paddr_u a);
    logic [15:0] base;
    int          w;
    base = {a.flat[15:4], 4'h0};
    w    = int'(a.fields.word);
    return {base ^ 16'h5a3c, 8'(w * 37), base[11:4] + 8'(w)};
  endfunction

  function automatic string test_name(input logic [1:0] id);
    case (id)
      2'd0:    return "random_mix";
      2'd1:    return "invalidate_refetch";
      default: return "flush_refetch";
    endcase
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_cnt_o++;
    test_chk++;
    if (exp !== act) begin
      $display("[FAIL] %s %s: expected %h, actual %h", test_name(test_id_i), name, exp, act);
      err_cnt_o++;
      test_err++;
    end
  endtask

  task automatic report(input string msg);
    $display("error: %s in %s at cycle %0d", msg, test_name(test_id_i), cyc);
    err_cnt_o++;
    test_err++;
  endtask

  always @(posedge clk_i) begin
    logic [11:0] ln;
    if (!rst_ni) begin
      // reset clears every valid bit
      for (int i = 0; i < 4096; i++) begin
        resident[i] = 1'b0;
        absent[i]   = 1'b1;
      end
      pending = 1'b0;
      cyc = 0;
      err_cnt_o = 0;
      check_cnt_o = 0;
      test_err = 0;
      test_chk = 0;
      flush_left = 0;
    end else begin
      cyc++;
      // the pulse cycle and one cycle per set keep the fetch port closed
      if (flush_i) flush_left = icache_pkg::num_sets + 1;
      if (flush_left > 0) begin
        if (fetch_ready_i) report("fetch_ready_o high while a flush is pending or running");
        flush_left--;
      end
      if (fetch_ready_i && pending && !fetch_valid_i) begin
        report("fetch_ready_o high while a fetch is in flight");
      end
      if (mem_inv_ack_i && fetch_req_i && fetch_ready_i) begin
        report("mem_inv_ack_o high while a fetch is accepted");
      end
      if (mem_inv_ack_i && pending && !fetch_valid_i) begin
        report("mem_inv_ack_o high while a fetch is in flight");
      end
      if (fetch_req_i && fetch_ready_i) begin
        pend_addr.flat = fetch_addr_i;
        ln             = fetch_addr_i[15:4];
        pending        = 1'b1;
        acc_cyc        = cyc;
        saw_req        = 1'b0;
        saw_miss       = 1'b0;
        exp_hit        = resident[ln];
        exp_miss       = absent[ln];
      end
      if (mem_req_i) begin
        saw_req = 1'b1;
        check_val("mem_addr", {pend_addr.flat[15:4], 4'h0}, 32'(mem_addr_i));
      end
      if (miss_i) saw_miss = 1'b1;
      if (fetch_valid_i) begin
        if (!pending) begin
          report("fetch_valid_o high with no accepted fetch");
        end else begin
          ln = pend_addr.flat[15:4];
          check_val("fetch_data", exp_word(pend_addr), fetch_data_i);
          if (exp_hit) begin
            check_val("hit_latency", 32'd2, 32'(cyc - acc_cyc));
            if (saw_req) report("refill request for a resident line");
          end
          if (exp_miss && !saw_miss) report("no miss_o for an invalidated or flushed line");
          // a fill leaves only the new line known in its set
          if (saw_req) begin
            for (int t = 0; t < 256; t++) resident[{t[7:0], pend_addr.fields.index}] = 1'b0;
            resident[ln] = 1'b1;
            absent[ln]   = 1'b0;
          end
          pending = 1'b0;
        end
      end
      if (mem_inv_req_i && mem_inv_ack_i) begin
        resident[mem_inv_addr_i[15:4]] = 1'b0;
        absent[mem_inv_addr_i[15:4]]   = 1'b1;
      end
      if (flush_i) begin
        for (int i = 0; i < 4096; i++) begin
          resident[i] = 1'b0;
          absent[i]   = 1'b1;
        end
      end
      if (test_end_i) begin
        $display("test %s finished: %0d checks, %0d errors",
                 test_name(test_id_i), test_chk, test_err);
        test_err = 0;
        test_chk = 0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/tb_top.sv ====
// testbench top of the instruction cache
// clock, reset, seeded fetch, invalidate and flush stimulus,
// refill memory responder, DUT instance, checker and watchdog

`default_nettype none

module tb_top;
  timeunit 1ns;
  timeprecision 1ps;

  // fetch budget of all three tests sizes the watchdog
  localparam int mix_ops     = 200;
  localparam int inv_rounds  = 16;
  localparam int fl_rounds   = 4;
  localparam int num_fetches = mix_ops + inv_rounds * 3 + fl_rounds * 16;

  logic         clk_i;
  logic         rst_ni;
  logic         flush_i;
  logic         fetch_req_i;
  logic [15:0]  fetch_addr_i;
  logic         fetch_ready_o;
  logic         fetch_valid_o;
  logic [31:0]  fetch_data_o;
  logic         miss_o;
  logic         mem_req_o;
  logic [15:0]  mem_addr_o;
  logic         mem_ack_i;
  logic         mem_rtrn_vld_i;
  logic [127:0] mem_rtrn_data_i;
  logic         mem_inv_req_i;
  logic [15:0]  mem_inv_addr_i;
  logic         mem_inv_ack_o;
  logic         test_end;
  logic [1:0]   test_id;
  int           err_cnt;
  int           check_cnt;

  icache_top u_icache_top (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .fetch_req_i     (fetch_req_i),
    .fetch_addr_i    (fetch_addr_i),
    .fetch_ready_o   (fetch_ready_o),
    .fetch_valid_o   (fetch_valid_o),
    .fetch_data_o    (fetch_data_o),
    .miss_o          (miss_o),
    .mem_req_o       (mem_req_o),
    .mem_addr_o      (mem_addr_o),
    .mem_ack_i       (mem_ack_i),
    .mem_rtrn_vld_i  (mem_rtrn_vld_i),
    .mem_rtrn_data_i (mem_rtrn_data_i),
    .mem_inv_req_i   (mem_inv_req_i),
    .mem_inv_addr_i  (mem_inv_addr_i),
    .mem_inv_ack_o   (mem_inv_ack_o)
  );

  tb_checker u_checker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .fetch_req_i    (fetch_req_i),
    .fetch_addr_i   (fetch_addr_i),
    .fetch_ready_i  (fetch_ready_o),
    .fetch_valid_i  (fetch_valid_o),
    .fetch_data_i   (fetch_data_o),
    .miss_i         (miss_o),
    .mem_req_i      (mem_req_o),
    .mem_addr_i     (mem_addr_o),
    .mem_inv_req_i  (mem_inv_req_i),
    .mem_inv_addr_i (mem_inv_addr_i),
    .mem_inv_ack_i  (mem_inv_ack_o),
    .test_end_i     (test_end),
    .test_id_i      (test_id),
    .err_cnt_o      (err_cnt),
    .check_cnt_o    (check_cnt)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // every memory word is tagged with its line and position
  function automatic logic [127:0] line_data(input logic [15:0] base);
    logic [127:0] d;
    d = '0;
    for (int w = 0; w < 4; w++) begin
      d[w*32 +: 32] = {base ^ 16'h5a3c, 8'(w * 37), base[11:4] + 8'(w)};
    end
    return d;
  endfunction

  // three tags in each of 4 sets force evictions
  function automatic logic [15:0] rand_addr();
    logic [3:0] tag;
    logic [3:0] set;
    logic [1:0] word;
    tag  = 4'($urandom_range(0, 2));
    set  = 4'($urandom_range(0, 3));
    word = 2'($urandom_range(0, 3));
    return {4'h0, tag, set, word, 2'b00};
  endfunction

  task automatic do_fetch(input logic [15:0] addr);
    fetch_req_i  <= 1'b1;
    fetch_addr_i <= addr;
    @(posedge clk_i);
    while (!fetch_ready_o) @(posedge clk_i);
    fetch_req_i <= 1'b0;
    @(posedge clk_i);
    while (!fetch_valid_o) @(posedge clk_i);
  endtask

  task automatic do_inval(input logic [15:0] addr);
    mem_inv_req_i  <= 1'b1;
    mem_inv_addr_i <= addr;
    @(posedge clk_i);
    while (!mem_inv_ack_o) @(posedge clk_i);
    mem_inv_req_i <= 1'b0;
  endtask

  task automatic do_flush();
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    @(posedge clk_i);
    while (!fetch_ready_o) @(posedge clk_i);
  endtask

  task automatic mark_test_end();
    test_end <= 1'b1;
    @(posedge clk_i);
    test_end <= 1'b0;
  endtask

  ////////////////////
  // refill responder
  ////////////////////

  initial begin
    logic [15:0] base;
    forever begin
      @(posedge clk_i);
      if (rst_ni && mem_req_o) begin
        base = mem_addr_o;
        repeat ($urandom_range(1, 5) - 1) @(posedge clk_i);
        mem_ack_i <= 1'b1;
        @(posedge clk_i);
        mem_ack_i <= 1'b0;
        repeat ($urandom_range(1, 6) - 1) @(posedge clk_i);
        mem_rtrn_vld_i  <= 1'b1;
        mem_rtrn_data_i <= line_data(base);
        @(posedge clk_i);
        mem_rtrn_vld_i <= 1'b0;
      end
    end
  end

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    logic [15:0] a;
    int unsigned pick;
    void'($urandom(33));
    rst_ni          = 1'b0;
    flush_i         = 1'b0;
    fetch_req_i     = 1'b0;
    fetch_addr_i    = '0;
    mem_ack_i       = 1'b0;
    mem_rtrn_vld_i  = 1'b0;
    mem_rtrn_data_i = '0;
    mem_inv_req_i   = 1'b0;
    mem_inv_addr_i  = '0;
    test_end        = 1'b0;
    test_id         = '0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    // mostly fetches, some invalidates and the odd flush
    for (int i = 0; i < mix_ops; i++) begin
      pick = $urandom_range(0, 99);
      if (pick < 85) do_fetch(rand_addr());
      else if (pick < 96) do_inval(rand_addr());
      else do_flush();
    end
    mark_test_end();
    test_id <= 2'd1;

    // fill, hit, invalidate, then a forced miss
    for (int i = 0; i < inv_rounds; i++) begin
      a = rand_addr();
      do_fetch(a);
      do_fetch(a);
      do_inval(a);
      do_fetch(a);
    end
    mark_test_end();
    test_id <= 2'd2;

    // eight resident lines, flush, fetch them all again
    for (int r = 0; r < fl_rounds; r++) begin
      for (int i = 0; i < 8; i++) do_fetch({8'(i[2:0] >> 2), 4'(i[1:0]), 4'(r * 4)});
      do_flush();
      for (int i = 0; i < 8; i++) do_fetch({8'(i[2:0] >> 2), 4'(i[1:0]), 4'(r * 4)});
    end
    mark_test_end();

    repeat (4) @(posedge clk_i);
    $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0 && check_cnt > 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (num_fetches * 40 + 8) @(posedge clk_i);
    $display("watchdog timeout: the run did not finish in time");
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
source/icache_pkg.sv
source/icache_tag_store.sv
source/icache_data_store.sv
source/icache_ctrl.sv
source/icache_top.sv
verification/tb_checker.sv
verification/tb_top.sv

// ==== Makefile ====
# Verilator build, run and lint of the instruction cache testbench

LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f all.f --top-module tb_top -o Vtb_top

run: build
	./obj_dir/Vtb_top > $(LOG) 2>&1; cat $(LOG)
	grep -q "All tests passed" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f all.f --top-module tb_top

clean:
	rm -rf obj_dir $(LOG)
